// ==== adc_defs.svh ====
`ifndef ADC_DEFS_SVH
`define ADC_DEFS_SVH

// Converter geometry, fixed by the ADC part

// Bits in one I or Q sample word
`define ADC_SAMPLE_W 8

// Samples per channel delivered in one adc_clk cycle
`define ADC_SAMPLES 4

// Clock phases at which the sync level is sampled
`define ADC_PHASES 4

// Width of the cycles-since-sync counter
`define ADC_FRAME_W 12

`endif

// ==== adc_pkg.sv ====
`default_nettype none

package adc_pkg;

`include "adc_defs.svh"

  // Two's-complement converter sample
  typedef logic [`ADC_SAMPLE_W-1:0] sample_t;

  // Sync level per phase, bit 0 is the earliest phase of the cycle
  typedef logic [`ADC_PHASES-1:0] sync_phase_t;

  // One over-range bit per half cycle, two samples each
  typedef logic [`ADC_SAMPLES/2-1:0] overrange_t;

  // Cycles elapsed since the last sync edge
  typedef logic [`ADC_FRAME_W-1:0] frame_cnt_t;

  localparam frame_cnt_t FRAME_MAX = '1;  // Counter holds here without a new sync edge

endpackage

`default_nettype wire

// ==== adc_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module adc_capture (
  input  wire                      adc_clk,
  input  wire                      arst_n,
  input  wire adc_pkg::sample_t    adc_i0,
  input  wire adc_pkg::sample_t    adc_i1,
  input  wire adc_pkg::sample_t    adc_i2,
  input  wire adc_pkg::sample_t    adc_i3,
  input  wire adc_pkg::sample_t    adc_q0,
  input  wire adc_pkg::sample_t    adc_q1,
  input  wire adc_pkg::sample_t    adc_q2,
  input  wire adc_pkg::sample_t    adc_q3,
  input  wire adc_pkg::sync_phase_t adc_sync,
  input  wire adc_pkg::overrange_t adc_overrange,
  output adc_pkg::sample_t         cap_i0,
  output adc_pkg::sample_t         cap_i1,
  output adc_pkg::sample_t         cap_i2,
  output adc_pkg::sample_t         cap_i3,
  output adc_pkg::sample_t         cap_q0,
  output adc_pkg::sample_t         cap_q1,
  output adc_pkg::sample_t         cap_q2,
  output adc_pkg::sample_t         cap_q3,
  output adc_pkg::sync_phase_t     cap_sync,
  output adc_pkg::overrange_t      cap_overrange,
  output logic                     cap_valid
);

  import adc_pkg::*;

  // Pin registers, one per lane
  always_ff @(posedge adc_clk) begin
    cap_i0        <= adc_i0;
    cap_i1        <= adc_i1;
    cap_i2        <= adc_i2;
    cap_i3        <= adc_i3;
    cap_q0        <= adc_q0;
    cap_q1        <= adc_q1;
    cap_q2        <= adc_q2;
    cap_q3        <= adc_q3;
    cap_sync      <= adc_sync;  // Raw phase levels, edge search happens downstream
    cap_overrange <= adc_overrange;
  end

  // Data counts as valid from the first edge after reset release
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      cap_valid <= 1'b0;
    end else begin
      cap_valid <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== adc_sync_edge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "adc_defs.svh"

module adc_sync_edge (
  input  wire                       adc_clk,
  input  wire                       arst_n,
  input  wire adc_pkg::sample_t     cap_i0,
  input  wire adc_pkg::sample_t     cap_i1,
  input  wire adc_pkg::sample_t     cap_i2,
  input  wire adc_pkg::sample_t     cap_i3,
  input  wire adc_pkg::sample_t     cap_q0,
  input  wire adc_pkg::sample_t     cap_q1,
  input  wire adc_pkg::sample_t     cap_q2,
  input  wire adc_pkg::sample_t     cap_q3,
  input  wire adc_pkg::sync_phase_t cap_sync,
  input  wire adc_pkg::overrange_t  cap_overrange,
  input  wire                       cap_valid,
  output adc_pkg::sample_t          edge_i0,
  output adc_pkg::sample_t          edge_i1,
  output adc_pkg::sample_t          edge_i2,
  output adc_pkg::sample_t          edge_i3,
  output adc_pkg::sample_t          edge_q0,
  output adc_pkg::sample_t          edge_q1,
  output adc_pkg::sample_t          edge_q2,
  output adc_pkg::sample_t          edge_q3,
  output adc_pkg::overrange_t       edge_overrange,
  output adc_pkg::sync_phase_t      sync_mark,
  output logic                      edge_valid
);

  import adc_pkg::*;

  logic        prev_phase3;  // Last phase of the previous valid cycle
  sync_phase_t sync_before;
  sync_phase_t sync_rise;
  sync_phase_t sync_first;

  // Each phase is compared with the one just before it in time
  always_comb begin
    sync_before = {cap_sync[`ADC_PHASES-2:0], prev_phase3};
    sync_rise   = cap_sync & ~sync_before;
    sync_first  = sync_rise & (~sync_rise + sync_phase_t'(1));  // Isolates the lowest set bit
  end

  // Starts high so that a sync already asserted at reset gives no edge
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      prev_phase3 <= 1'b1;
    end else if (cap_valid) begin
      prev_phase3 <= cap_sync[`ADC_PHASES-1];
    end
  end

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      sync_mark  <= '0;
      edge_valid <= 1'b0;
    end else begin
      sync_mark  <= cap_valid ? sync_first : '0;
      edge_valid <= cap_valid;
    end
  end

  // Samples move alongside the marker so both leave in the same cycle
  always_ff @(posedge adc_clk) begin
    edge_i0        <= cap_i0;
    edge_i1        <= cap_i1;
    edge_i2        <= cap_i2;
    edge_i3        <= cap_i3;
    edge_q0        <= cap_q0;
    edge_q1        <= cap_q1;
    edge_q2        <= cap_q2;
    edge_q3        <= cap_q3;
    edge_overrange <= cap_overrange;
  end

endmodule

`default_nettype wire

// ==== adc_frame_output.sv ====
`timescale 1ns/1ps
`default_nettype none

module adc_frame_output (
  input  wire                       adc_clk,
  input  wire                       arst_n,
  input  wire adc_pkg::sample_t     edge_i0,
  input  wire adc_pkg::sample_t     edge_i1,
  input  wire adc_pkg::sample_t     edge_i2,
  input  wire adc_pkg::sample_t     edge_i3,
  input  wire adc_pkg::sample_t     edge_q0,
  input  wire adc_pkg::sample_t     edge_q1,
  input  wire adc_pkg::sample_t     edge_q2,
  input  wire adc_pkg::sample_t     edge_q3,
  input  wire adc_pkg::overrange_t  edge_overrange,
  input  wire adc_pkg::sync_phase_t sync_mark,
  input  wire                       edge_valid,
  input  wire                       overrange_clear,
  output adc_pkg::sample_t          user_datai0,
  output adc_pkg::sample_t          user_datai1,
  output adc_pkg::sample_t          user_datai2,
  output adc_pkg::sample_t          user_datai3,
  output adc_pkg::sample_t          user_dataq0,
  output adc_pkg::sample_t          user_dataq1,
  output adc_pkg::sample_t          user_dataq2,
  output adc_pkg::sample_t          user_dataq3,
  output adc_pkg::sync_phase_t      user_sync,
  output adc_pkg::overrange_t       user_overrange,
  output logic                      user_overrange_sticky,
  output adc_pkg::frame_cnt_t       user_frame_count,
  output logic                      user_data_valid
);

  import adc_pkg::*;

  logic       clear_d1;
  logic       clear_d2;  // Lines up with the item now leaving the sync stage
  logic       sticky_held;
  logic       overrange_hit;
  frame_cnt_t count_next;

  always_comb begin
    sticky_held   = user_overrange_sticky & ~clear_d2;
    overrange_hit = edge_valid & (|edge_overrange);  // A new hit beats a clear
    if (!edge_valid) begin
      count_next = user_frame_count;
    end else if (|sync_mark) begin
      count_next = '0;
    end else if (user_frame_count == FRAME_MAX) begin
      count_next = FRAME_MAX;
    end else begin
      count_next = user_frame_count + frame_cnt_t'(1);
    end
  end

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      clear_d1              <= 1'b0;
      clear_d2              <= 1'b0;
      user_sync             <= '0;
      user_overrange_sticky <= 1'b0;
      user_frame_count      <= '0;
      user_data_valid       <= 1'b0;
    end else begin
      clear_d1              <= overrange_clear;
      clear_d2              <= clear_d1;
      user_sync             <= sync_mark;
      user_overrange_sticky <= sticky_held | overrange_hit;
      user_frame_count      <= count_next;
      user_data_valid       <= edge_valid;
    end
  end

  always_ff @(posedge adc_clk) begin
    user_datai0    <= edge_i0;
    user_datai1    <= edge_i1;
    user_datai2    <= edge_i2;
    user_datai3    <= edge_i3;
    user_dataq0    <= edge_q0;
    user_dataq1    <= edge_q1;
    user_dataq2    <= edge_q2;
    user_dataq3    <= edge_q3;
    user_overrange <= edge_overrange;
  end

endmodule

`default_nettype wire

// ==== adc_interface_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module adc_interface_top (
  input  wire                       adc_clk,
  input  wire                       arst_n,
  input  wire adc_pkg::sample_t     adc_i0,
  input  wire adc_pkg::sample_t     adc_i1,
  input  wire adc_pkg::sample_t     adc_i2,
  input  wire adc_pkg::sample_t     adc_i3,
  input  wire adc_pkg::sample_t     adc_q0,
  input  wire adc_pkg::sample_t     adc_q1,
  input  wire adc_pkg::sample_t     adc_q2,
  input  wire adc_pkg::sample_t     adc_q3,
  input  wire adc_pkg::sync_phase_t adc_sync,
  input  wire adc_pkg::overrange_t  adc_overrange,
  input  wire                       overrange_clear,
  output wire adc_pkg::sample_t     user_datai0,
  output wire adc_pkg::sample_t     user_datai1,
  output wire adc_pkg::sample_t     user_datai2,
  output wire adc_pkg::sample_t     user_datai3,
  output wire adc_pkg::sample_t     user_dataq0,
  output wire adc_pkg::sample_t     user_dataq1,
  output wire adc_pkg::sample_t     user_dataq2,
  output wire adc_pkg::sample_t     user_dataq3,
  output wire adc_pkg::sync_phase_t user_sync,
  output wire adc_pkg::overrange_t  user_overrange,
  output wire                       user_overrange_sticky,
  output wire adc_pkg::frame_cnt_t  user_frame_count,
  output wire                       user_data_valid
);

  import adc_pkg::*;

  // Capture to sync-edge stage
  wire sample_t     cap_i0, cap_i1, cap_i2, cap_i3;
  wire sample_t     cap_q0, cap_q1, cap_q2, cap_q3;
  wire sync_phase_t cap_sync;
  wire overrange_t  cap_overrange;
  wire              cap_valid;

  // Sync-edge to output stage
  wire sample_t     edge_i0, edge_i1, edge_i2, edge_i3;
  wire sample_t     edge_q0, edge_q1, edge_q2, edge_q3;
  wire overrange_t  edge_overrange;
  wire sync_phase_t sync_mark;
  wire              edge_valid;

  // Port names match the wire names stage to stage
  adc_capture capture_i (.*);

  adc_sync_edge sync_edge_i (.*);

  adc_frame_output frame_output_i (.*);

endmodule

`default_nettype wire

// ==== adc_interface_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module adc_interface_checker (
  input wire                       adc_clk,
  input wire                       arst_n,
  input wire adc_pkg::sync_phase_t user_sync,
  input wire adc_pkg::frame_cnt_t  user_frame_count,
  input wire                       user_data_valid
);

  import adc_pkg::*;

  // Only the lowest rising phase is ever marked
  sync_onehot: assert property (@(posedge adc_clk) disable iff (!arst_n) $onehot0(user_sync))
    else $error("user_sync has more than one phase marked");

  valid_in_reset: assert property (@(posedge adc_clk) !arst_n |-> !user_data_valid)
    else $error("user_data_valid high during reset");

  mark_clears_count: assert property (@(posedge adc_clk) disable iff (!arst_n)
    (|user_sync) |-> (user_frame_count == '0))
    else $error("frame count not zero on a marked sync edge");

endmodule

`default_nettype wire

// ==== tb_adc_interface.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_adc_interface;

  import adc_pkg::*;

  localparam int RUN_LIMIT = 6000;

  logic adc_clk, arst_n, cur_clear;
  sample_t cur_i [4];
  sample_t cur_q [4];
  sync_phase_t cur_sync;
  overrange_t cur_ovr;
  wire sample_t out_i [4];
  wire sample_t out_q [4];
  wire sync_phase_t user_sync;
  wire overrange_t user_overrange;
  wire user_overrange_sticky, user_data_valid;
  wire frame_cnt_t user_frame_count;

  sample_t lane_q [$];  // Eight lanes per item in flight
  overrange_t ovr_q [$];
  sync_phase_t mark_q [$];
  frame_cnt_t count_q [$];
  logic sticky_q [$];
  logic valid_q [$];
  frame_cnt_t model_count;
  logic model_sticky, first_item;
  int data_errors, sync_errors, count_errors, flag_errors, other_errors;

  adc_interface_top dut_i (
    .adc_clk(adc_clk), .arst_n(arst_n),
    .adc_i0(cur_i[0]), .adc_i1(cur_i[1]), .adc_i2(cur_i[2]), .adc_i3(cur_i[3]),
    .adc_q0(cur_q[0]), .adc_q1(cur_q[1]), .adc_q2(cur_q[2]), .adc_q3(cur_q[3]),
    .adc_sync(cur_sync), .adc_overrange(cur_ovr), .overrange_clear(cur_clear),
    .user_datai0(out_i[0]), .user_datai1(out_i[1]), .user_datai2(out_i[2]),
    .user_datai3(out_i[3]), .user_dataq0(out_q[0]), .user_dataq1(out_q[1]),
    .user_dataq2(out_q[2]), .user_dataq3(out_q[3]), .user_sync(user_sync),
    .user_overrange(user_overrange), .user_overrange_sticky(user_overrange_sticky),
    .user_frame_count(user_frame_count), .user_data_valid(user_data_valid)
  );

  bind adc_interface_top adc_interface_checker checker_i (.*);

  always #4 adc_clk = ~adc_clk;

  task automatic check_sample(input string name, input sample_t exp, input sample_t act);
    if (act !== exp) begin
      data_errors++;
      $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_overrange(input string name, input overrange_t exp, input overrange_t act);
    if (act !== exp) begin
      data_errors++;
      $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_sync(input string name, input sync_phase_t exp, input sync_phase_t act);
    if (act !== exp) begin
      sync_errors++;
      $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input frame_cnt_t exp, input frame_cnt_t act);
    if (act !== exp) begin
      count_errors++;
      $display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      flag_errors++;
      $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic push_item(input sync_phase_t mark, input frame_cnt_t cnt, input logic sticky,
                           input logic valid);
    for (int k = 0; k < 4; k++) lane_q.push_back(cur_i[k]);
    for (int k = 0; k < 4; k++) lane_q.push_back(cur_q[k]);
    ovr_q.push_back(cur_ovr);
    mark_q.push_back(mark);
    count_q.push_back(cnt);
    sticky_q.push_back(sticky);
    valid_q.push_back(valid);
    model_count = cnt;
    model_sticky = sticky;
  endtask

  task automatic compare_oldest();
    for (int k = 0; k < 4; k++) begin
      check_sample($sformatf("user_datai%0d", k), lane_q.pop_front(), out_i[k]);
    end
    for (int k = 0; k < 4; k++) begin
      check_sample($sformatf("user_dataq%0d", k), lane_q.pop_front(), out_q[k]);
    end
    check_overrange("user_overrange", ovr_q.pop_front(), user_overrange);
    check_sync("user_sync", mark_q.pop_front(), user_sync);
    check_count("user_frame_count", count_q.pop_front(), user_frame_count);
    check_bit("user_overrange_sticky", sticky_q.pop_front(), user_overrange_sticky);
    check_bit("user_data_valid", valid_q.pop_front(), user_data_valid);
  endtask

  // Advances one cycle; outputs are inactive until the first item has crossed all three stages
  task automatic next_cycle(input bit draining);
    if (!first_item) begin
      @(posedge adc_clk);
      #1;
      if (draining || valid_q.size() == 3) begin
        compare_oldest();
      end else begin
        check_bit("user_data_valid", 1'b0, user_data_valid);
        check_sync("user_sync", '0, user_sync);
        check_count("user_frame_count", '0, user_frame_count);
        check_bit("user_overrange_sticky", 1'b0, user_overrange_sticky);
      end
    end
    first_item = 1'b0;
  endtask

  task automatic run_vectors(input int fd);
    string line;
    int n;
    int got;
    sample_t in_i [4];
    sample_t in_q [4];
    sync_phase_t in_sync;
    overrange_t in_ovr;
    logic in_clear;
    sync_phase_t mark;
    frame_cnt_t cnt;
    logic sticky, valid;
    while (!$feof(fd)) begin
      got = $fgets(line, fd);
      if (got == 0 || line.len() < 2 || line.getc(0) == 8'h23) continue;
      if ($sscanf(line, "repeat %d", n) == 1) begin
        for (int r = 0; r < n; r++) begin
          next_cycle(1'b0);
          cnt = (model_count == frame_cnt_t'('1)) ? model_count : model_count + frame_cnt_t'(1);
          push_item('0, cnt, (model_sticky & ~cur_clear) | (|cur_ovr), 1'b1);
        end
      end else begin
        got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      in_i[0], in_i[1], in_i[2], in_i[3], in_q[0], in_q[1], in_q[2],
                      in_q[3], in_sync, in_ovr, in_clear, mark, cnt, sticky, valid);
        if (got != 15) begin
          other_errors++;
          $display("Test data line could not be read: %s", line);
        end else begin
          next_cycle(1'b0);
          cur_i = in_i;  // New stimulus goes out 1 ns after the edge
          cur_q = in_q;
          cur_sync = in_sync;
          cur_ovr = in_ovr;
          cur_clear = in_clear;
          push_item(mark, cnt, sticky, valid);
        end
      end
    end
    for (int d = 0; d < 3 && valid_q.size() > 0; d++) next_cycle(1'b1);
  endtask

  initial begin : watchdog
    for (int c = 0; c < RUN_LIMIT; c++) @(posedge adc_clk);
    $display("Simulation did not finish within %0d cycles", RUN_LIMIT);
    $display(">>> FAIL");
    $finish;
  end

  initial begin : main
    int fd;
    int total;
    adc_clk = 1'b0;
    arst_n = 1'b0;
    cur_clear = 1'b0;
    cur_sync = '0;
    cur_ovr = '0;
    for (int k = 0; k < 4; k++) begin
      cur_i[k] = '0;
      cur_q[k] = '0;
    end
    first_item = 1'b1;
    model_count = '0;
    model_sticky = 1'b0;
    repeat (3) @(posedge adc_clk);
    #1;
    arst_n = 1'b1;
    fd = $fopen("adc_testdata.txt", "r");
    if (fd != 0) begin
      run_vectors(fd);
      $fclose(fd);
    end else begin
      other_errors++;
      $display("Test data file adc_testdata.txt could not be opened");
    end
    total = data_errors + sync_errors + count_errors + flag_errors + other_errors;
    $display("Errors: data %0d, sync %0d, count %0d, flags %0d, other %0d", data_errors,
             sync_errors, count_errors, flag_errors, other_errors);
    if (total == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== adc_testdata.txt ====
# i0 i1 i2 i3 q0 q1 q2 q3 sync ovr clear | expected for the same item: mark count sticky valid
# All fields hex; "repeat n" holds the previous stimulus for n more cycles
10 11 12 13 20 21 22 23 f 0 0 0 001 0 1
7f 80 ff 00 01 fe 55 aa 0 0 0 0 002 0 1
31 32 33 34 41 42 43 44 1 1 0 1 000 1 1
00 ff 00 ff ff 00 ff 00 0 0 0 0 001 1 1
5a a5 5a a5 c3 3c c3 3c 2 0 0 2 000 1 1
61 62 63 64 71 72 73 74 0 0 1 0 001 0 1
81 82 83 84 91 92 93 94 4 0 0 4 000 0 1
a1 a2 a3 a4 b1 b2 b3 b4 0 2 0 0 001 1 1
c1 c2 c3 c4 d1 d2 d3 d4 8 1 1 8 000 1 1
e1 e2 e3 e4 f1 f2 f3 f4 0 0 0 0 001 1 1
01 23 45 67 89 ab cd ef c 0 1 4 000 0 1
fe dc ba 98 76 54 32 10 0 0 0 0 001 0 1
80 80 80 80 7f 7f 7f 7f f 0 0 1 000 0 1
11 22 33 44 55 66 77 88 f 0 0 0 001 0 1
99 aa bb cc dd ee ff 00 f 3 0 0 002 1 1
0f 1e 2d 3c 4b 5a 69 78 0 0 0 0 003 1 1
87 96 a5 b4 c3 d2 e1 f0 5 0 1 1 000 0 1
12 34 56 78 9a bc de f0 0 2 0 0 001 1 1
repeat 4100
24 68 ac e0 13 57 9b df 0 0 1 0 fff 0 1
3c 3c 3c 3c c3 c3 c3 c3 2 0 0 2 000 0 1
ee dd cc bb aa 99 88 77 0 3 0 0 001 1 1

// ==== list.f ====
+incdir+.
adc_pkg.sv
adc_capture.sv
adc_sync_edge.sv
adc_frame_output.sv
adc_interface_top.sv
adc_interface_checker.sv
tb_adc_interface.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_adc_interface -f list.f -o sim_adc

./obj_dir/sim_adc 2>&1 | tee sim.log

if grep -qx ">>> PASS" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
